// ==== spmv_params.svh ====
`ifndef SPMV_PARAMS_SVH
`define SPMV_PARAMS_SVH

// Matrix values and x elements
`define SPMV_DATA_WIDTH 16

// Accumulator, wraps modulo 2**40
`define SPMV_ACC_WIDTH  40

`define SPMV_VEC_LEN    16
`define SPMV_ADDR_WIDTH 4

// Row numbers, row count and row pointers
`define SPMV_ROW_WIDTH  8

`endif

// ==== spmv_pkg.sv ====
`include "spmv_params.svh"

package spmv_pkg;

    typedef struct packed {
        logic [`SPMV_ROW_WIDTH-1:0] row_end;  // Cumulative nonzero count
    } row_ptr_beat_t;

    typedef struct packed {
        logic signed [`SPMV_DATA_WIDTH-1:0] value;
    } val_beat_t;

    typedef struct packed {
        logic [`SPMV_ADDR_WIDTH-1:0] col;
    } col_beat_t;

    // x load port
    typedef struct packed {
        logic                         en;
        logic [`SPMV_ADDR_WIDTH-1:0]  addr;
        logic [`SPMV_DATA_WIDTH-1:0]  data;
    } vec_wr_t;

    typedef struct packed {
        logic                         en;
        logic [`SPMV_ADDR_WIDTH-1:0]  addr;
    } vec_rd_t;

    typedef struct packed {
        logic signed [`SPMV_DATA_WIDTH-1:0] value;
        logic                               first;  // Start a new row
        logic                               last;   // Emit at end of row
    } mac_in_t;

    typedef struct packed {
        logic [`SPMV_ROW_WIDTH-1:0] row;
        logic [`SPMV_ACC_WIDTH-1:0] sum;
    } result_t;

endpackage

// ==== spmv_vector_ram.sv ====
`timescale 1ns/100ps
`include "spmv_params.svh"

module spmv_vector_ram (
    input  logic                          clk,
    input  logic                          rst_n,

    input  spmv_pkg::vec_wr_t             wr,
    input  spmv_pkg::vec_rd_t             rd,
    output logic [`SPMV_DATA_WIDTH-1:0]   rd_data
);

    logic [`SPMV_DATA_WIDTH-1:0] mem [`SPMV_VEC_LEN];

    always_ff @(posedge clk)
    begin
        if (wr.en)
        begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Registered read, data holds between requests
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rd_data <= '0;
        end
        else if (rd.en)
        begin
            rd_data <= mem[rd.addr];
        end
    end

endmodule

// ==== spmv_mac.sv ====
`timescale 1ns/100ps
`include "spmv_params.svh"

module spmv_mac (
    input  logic                          clk,
    input  logic                          rst_n,

    input  spmv_pkg::mac_in_t             in,
    input  logic [`SPMV_DATA_WIDTH-1:0]   multiplicand,
    input  logic                          in_valid,
    output logic                          in_ready,

    output logic [`SPMV_ACC_WIDTH-1:0]    out_sum,
    output logic                          out_valid,
    input  logic                          out_ready
);

    logic signed [2*`SPMV_DATA_WIDTH-1:0] product;
    logic                                 p_valid;
    logic signed [2*`SPMV_DATA_WIDTH-1:0] p_prod;
    logic                                 p_first;
    logic                                 p_last;
    logic signed [`SPMV_ACC_WIDTH-1:0]    p_ext;
    logic signed [`SPMV_ACC_WIDTH-1:0]    acc;
    logic                                 hold;

    assign product = $signed(in.value) * $signed(multiplicand);
    assign p_ext   = p_prod;                    // Sign extended
    assign hold    = out_valid && !out_ready;   // Finished sum not yet taken

    // Product stage may refill only when it empties or is already empty
    assign in_ready = !p_valid || !hold;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            p_valid <= 1'b0;
        end
        else if (in_ready)
        begin
            p_valid <= in_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_valid && in_ready)
        begin
            p_prod  <= product;
            p_first <= in.first;
            p_last  <= in.last;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            out_valid <= 1'b0;
        end
        else if (!hold)
        begin
            out_valid <= p_valid && p_last;
        end
    end

    // Wraps at the accumulator width
    always_ff @(posedge clk)
    begin
        if (p_valid && !hold)
        begin
            acc <= p_first ? p_ext : acc + p_ext;
        end
    end

    assign out_sum = acc;

endmodule

// ==== spmv_kernel.sv ====
`timescale 1ns/100ps
`include "spmv_params.svh"

module spmv_kernel (
    input  logic                          clk,
    input  logic                          rst_n,

    input  logic                          en,
    input  logic [`SPMV_ROW_WIDTH-1:0]    num_rows,
    output logic                          done,

    input  spmv_pkg::row_ptr_beat_t       row_ptr,
    input  logic                          row_ptr_valid,
    output logic                          row_ptr_ready,
    input  spmv_pkg::val_beat_t           val,
    input  logic                          val_valid,
    output logic                          val_ready,
    input  spmv_pkg::col_beat_t           col,
    input  logic                          col_valid,
    output logic                          col_ready,

    output spmv_pkg::vec_rd_t             vec_rd,
    input  logic [`SPMV_DATA_WIDTH-1:0]   x_data,

    output spmv_pkg::result_t             res,
    output logic                          res_valid,
    input  logic                          res_ready
);

    typedef enum logic {
        IDLE,
        BUSY
    } state_t;

    state_t                       state_r;
    state_t                       state_b;

    logic [`SPMV_ROW_WIDTH-1:0]   rows_r;       // Row count latched at start
    logic [`SPMV_ROW_WIDTH-1:0]   issued_cnt;   // Row pointers taken
    logic [`SPMV_ROW_WIDTH-1:0]   res_cnt;      // Results accepted, also the row tag
    logic [`SPMV_ROW_WIDTH-1:0]   nnz_cnt;
    logic [`SPMV_ROW_WIDTH-1:0]   row_end_r;
    logic                         have_ptr;
    logic                         first_pend;

    // Read request stage, then data stage aligned with x_data
    logic                         r_valid;
    spmv_pkg::mac_in_t            r_elem;
    logic [`SPMV_ADDR_WIDTH-1:0]  r_addr;
    logic                         d_valid;
    spmv_pkg::mac_in_t            d_elem;

    logic                         start;
    logic                         d_free;
    logic                         r_accept;
    logic                         mac_ready;
    logic                         row_empty;
    logic                         ptr_go;
    logic                         empty_go;
    logic                         beat_go;
    logic                         issue;
    logic                         issue_last;
    logic                         res_go;
    logic                         last_res;
    logic [`SPMV_ACC_WIDTH-1:0]   mac_sum;

    assign start     = (state_r == IDLE) && en;
    assign d_free    = !d_valid || mac_ready;
    assign r_accept  = !r_valid || d_free;
    assign row_empty = (nnz_cnt == row_end_r);

    assign row_ptr_ready = (state_r == BUSY) && !have_ptr && (issued_cnt != rows_r) && r_accept;
    assign ptr_go        = row_ptr_valid && row_ptr_ready;

    // Empty row sends a single zero element
    assign empty_go   = have_ptr && row_empty && r_accept;
    assign beat_go    = have_ptr && !row_empty && val_valid && col_valid && r_accept;
    assign val_ready  = beat_go;
    assign col_ready  = beat_go;
    assign issue      = empty_go || beat_go;
    assign issue_last = empty_go || ((nnz_cnt + 1'b1) == row_end_r);

    assign res_go   = res_valid && res_ready;
    assign last_res = res_go && (res_cnt == rows_r - 1'b1);

    assign vec_rd = '{en: r_valid && d_free, addr: r_addr};
    assign res    = '{row: res_cnt, sum: mac_sum};

    always_comb
    begin
        state_b = state_r;

        case (state_r)
            IDLE:
            begin
                if (en)
                begin
                    state_b = BUSY;
                end
            end
            BUSY:
            begin
                if (last_res)
                begin
                    state_b = IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state_r    <= IDLE;
            done       <= 1'b0;
            rows_r     <= '0;
            issued_cnt <= '0;
            res_cnt    <= '0;
            nnz_cnt    <= '0;
            have_ptr   <= 1'b0;
            first_pend <= 1'b0;
        end
        else
        begin
            state_r <= state_b;
            done    <= last_res;

            if (start)
            begin
                rows_r     <= num_rows;
                issued_cnt <= '0;
                res_cnt    <= '0;
                nnz_cnt    <= '0;
                have_ptr   <= 1'b0;
            end
            else
            begin
                if (ptr_go)
                begin
                    have_ptr   <= 1'b1;
                    first_pend <= 1'b1;
                    issued_cnt <= issued_cnt + 1'b1;
                end
                if (issue)
                begin
                    first_pend <= 1'b0;
                    if (issue_last)
                    begin
                        have_ptr <= 1'b0;   // Row complete
                    end
                end
                if (beat_go)
                begin
                    nnz_cnt <= nnz_cnt + 1'b1;
                end
                if (res_go)
                begin
                    res_cnt <= res_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (ptr_go)
        begin
            row_end_r <= row_ptr.row_end;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            r_valid <= 1'b0;
            d_valid <= 1'b0;
        end
        else
        begin
            if (r_accept)
            begin
                r_valid <= issue;
            end
            if (d_free)
            begin
                d_valid <= r_valid;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            r_elem.value <= beat_go ? val.value : '0;
            r_elem.first <= first_pend;
            r_elem.last  <= issue_last;
            r_addr       <= col.col;    // Don't care for an empty row
        end
        if (r_valid && d_free)
        begin
            d_elem <= r_elem;
        end
    end

    spmv_mac u_mac (
        .clk          (clk),
        .rst_n        (rst_n),
        .in           (d_elem),
        .multiplicand (x_data),
        .in_valid     (d_valid),
        .in_ready     (mac_ready),
        .out_sum      (mac_sum),
        .out_valid    (res_valid),
        .out_ready    (res_ready)
    );

endmodule

// ==== spmv_top.sv ====
`timescale 1ns/100ps
`include "spmv_params.svh"

module spmv_top (
    input  logic                          clk,
    input  logic                          rst_n,

    input  spmv_pkg::vec_wr_t             vec_wr,

    input  logic                          en,
    input  logic [`SPMV_ROW_WIDTH-1:0]    num_rows,
    output logic                          done,

    input  spmv_pkg::row_ptr_beat_t       row_ptr,
    input  logic                          row_ptr_valid,
    output logic                          row_ptr_ready,
    input  spmv_pkg::val_beat_t           val,
    input  logic                          val_valid,
    output logic                          val_ready,
    input  spmv_pkg::col_beat_t           col,
    input  logic                          col_valid,
    output logic                          col_ready,

    output spmv_pkg::result_t             res,
    output logic                          res_valid,
    input  logic                          res_ready
);

    spmv_pkg::vec_rd_t            vec_rd;
    logic [`SPMV_DATA_WIDTH-1:0]  x_data;

    spmv_vector_ram u_vector_ram (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (vec_wr),
        .rd      (vec_rd),
        .rd_data (x_data)
    );

    spmv_kernel u_kernel (
        .clk           (clk),
        .rst_n         (rst_n),
        .en            (en),
        .num_rows      (num_rows),
        .done          (done),
        .row_ptr       (row_ptr),
        .row_ptr_valid (row_ptr_valid),
        .row_ptr_ready (row_ptr_ready),
        .val           (val),
        .val_valid     (val_valid),
        .val_ready     (val_ready),
        .col           (col),
        .col_valid     (col_valid),
        .col_ready     (col_ready),
        .vec_rd        (vec_rd),
        .x_data        (x_data),
        .res           (res),
        .res_valid     (res_valid),
        .res_ready     (res_ready)
    );

endmodule

// ==== spmv_chk.sv ====
`timescale 1ns/100ps
`include "spmv_params.svh"

module spmv_chk (
    input  logic                 clk,
    input  logic                 rst_n,
    input  spmv_pkg::result_t    res,
    input  logic                 res_valid,
    input  logic                 res_ready,
    input  logic                 done,
    input  logic                 row_ptr_ready,
    input  logic                 val_ready,
    input  logic                 col_ready
);

    // Stalled result holds
    assert property (@(posedge clk) disable iff (!rst_n)
        res_valid && !res_ready |=> res_valid && $stable(res))
        else $error("res changed while stalled");

    assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("done longer than one cycle");

    // Checked from the second reset cycle on
    assert property (@(posedge clk) !rst_n ##1 !rst_n |-> !row_ptr_ready && !val_ready && !col_ready)
        else $error("stream ready high during reset");

endmodule

bind spmv_top spmv_chk u_chk (.*);

// ==== spmv_tb.sv ====
`timescale 1ns/100ps
`include "spmv_params.svh"

module spmv_tb;

    localparam int SAMPLE_DELAY = 15;   // Late in the low phase, before the rising edge
    localparam int RUN_TIMEOUT  = 3000;

    logic                          clk = 1'b0;
    logic                          rst_n;
    spmv_pkg::vec_wr_t             vec_wr;
    logic                          en;
    logic [`SPMV_ROW_WIDTH-1:0]    num_rows;
    logic                          done;
    spmv_pkg::row_ptr_beat_t       row_ptr;
    logic                          row_ptr_valid;
    logic                          row_ptr_ready;
    spmv_pkg::val_beat_t           val;
    logic                          val_valid;
    logic                          val_ready;
    spmv_pkg::col_beat_t           col;
    logic                          col_valid;
    logic                          col_ready;
    spmv_pkg::result_t             res;
    logic                          res_valid;
    logic                          res_ready;

    // Matrix in CSR form and the x copy of the model
    logic [`SPMV_ROW_WIDTH-1:0]          row_end_q [64];
    logic signed [`SPMV_DATA_WIDTH-1:0]  val_q [256];
    logic [`SPMV_ADDR_WIDTH-1:0]         col_q [256];
    logic signed [`SPMV_DATA_WIDTH-1:0]  xm [`SPMV_VEC_LEN];
    int                                  n_rows;
    int                                  nnz;
    int                                  mismatch_errs = 0;
    int                                  other_errs = 0;

    spmv_top dut (.*);

    always #20 clk = ~clk;

    task idle_inputs();
        vec_wr        = '0;
        en            = 1'b0;
        num_rows      = '0;
        row_ptr       = '0;
        row_ptr_valid = 1'b0;
        val           = '0;
        val_valid     = 1'b0;
        col           = '0;
        col_valid     = 1'b0;
        res_ready     = 1'b1;
    endtask

    task apply_reset();
        @(negedge clk);
        idle_inputs();
        rst_n = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // Extremes show up often
    function logic signed [`SPMV_DATA_WIDTH-1:0] pick_data();
        logic signed [`SPMV_DATA_WIDTH-1:0] v;
        case ($urandom % 8)
            0:       v = 16'sh8000;
            1:       v = 16'sh7fff;
            2:       v = -16'sd1;
            default: v = $urandom;
        endcase
        return v;
    endfunction

    task clear_matrix();
        n_rows = 0;
        nnz    = 0;
    endtask

    task add_row(input int len, input bit in_order);
        for (int k = 0; k < len; k++)
        begin
            val_q[nnz] = pick_data();
            if (val_q[nnz] == 0)
                val_q[nnz] = 16'sd1;    // Stored entries are nonzero
            col_q[nnz] = in_order ? k : $urandom % `SPMV_VEC_LEN;
            nnz++;
        end
        row_end_q[n_rows] = nnz;
        n_rows++;
    endtask

    task build_random(input int rows);
        clear_matrix();
        for (int r = 0; r < rows; r++)
            add_row($urandom % 7, 1'b0);
    endtask

    task load_x();
        for (int i = 0; i < `SPMV_VEC_LEN; i++)
        begin
            xm[i] = pick_data();
            @(negedge clk);
            vec_wr = '{en: 1'b1, addr: 4'(i), data: xm[i]};
        end
        @(negedge clk);
        vec_wr = '0;
    endtask

    function logic [`SPMV_ACC_WIDTH-1:0] expected_sum(input int r);
        logic signed [`SPMV_ACC_WIDTH-1:0]    acc;
        logic signed [2*`SPMV_DATA_WIDTH-1:0] p;
        int                                   k;
        acc = '0;
        for (k = (r == 0) ? 0 : row_end_q[r-1]; k < row_end_q[r]; k++)
        begin
            p   = val_q[k] * xm[col_q[k]];
            acc = acc + p;  // Wraps at 40 bits
        end
        return acc;
    endfunction

    task check_result(input string name, input int idx);
        logic [`SPMV_ACC_WIDTH-1:0] exp_sum;
        if (idx >= n_rows)
        begin
            $display("Error in %s: extra result for row %0d", name, res.row);
            other_errs++;
        end
        else
        begin
            exp_sum = expected_sum(idx);
            if (res.row != idx[`SPMV_ROW_WIDTH-1:0])
            begin
                $display("Mismatch in %s row tag: expected %0d, actual %0d", name, idx, res.row);
                mismatch_errs++;
            end
            if (res.sum != exp_sum)
            begin
                $display("Mismatch in %s row %0d sum: expected %0d, actual %0d",
                         name, idx, $signed(exp_sum), $signed(res.sum));
                mismatch_errs++;
            end
        end
    endtask

    // Streams the current matrix, collects results until done
    task run_matrix(input string name, input bit gaps, input bit bp);
        int rp_i;
        int v_i;
        int c_i;
        int r_i;
        int cycles;
        bit rp_hold;
        bit v_hold;
        bit c_hold;
        bit finished;
        rp_i = 0;
        v_i = 0;
        c_i = 0;
        r_i = 0;
        cycles = 0;
        rp_hold = 0;
        v_hold = 0;
        c_hold = 0;
        finished = 0;
        @(negedge clk);
        en       = 1'b1;
        num_rows = n_rows;
        do
        begin
            @(negedge clk);
            en = 1'b0;
            if (!rp_hold)
            begin
                row_ptr_valid = (rp_i < n_rows) && (!gaps || ($urandom % 3 == 0));
                row_ptr.row_end = row_end_q[rp_i];
            end
            if (!v_hold)
            begin
                val_valid = (v_i < nnz) && (!gaps || ($urandom % 2 == 0));
                val.value = val_q[v_i];
            end
            if (!c_hold)
            begin
                col_valid = (c_i < nnz) && (!gaps || ($urandom % 2 == 0));
                col.col   = col_q[c_i];
            end
            res_ready = !bp || ($urandom % 2 == 0);
            #(SAMPLE_DELAY);
            rp_hold = row_ptr_valid && !row_ptr_ready;
            v_hold  = val_valid && !val_ready;
            c_hold  = col_valid && !col_ready;
            if (row_ptr_valid && row_ptr_ready) rp_i++;
            if (val_valid && val_ready) v_i++;
            if (col_valid && col_ready) c_i++;
            if (res_valid && res_ready)
            begin
                check_result(name, r_i);
                r_i++;
            end
            if (done)
                finished = 1;
            cycles++;
        end
        while (!finished && cycles < RUN_TIMEOUT);
        @(negedge clk);
        idle_inputs();
        if (!finished)
        begin
            $display("Timeout in %s: done did not pulse within %0d cycles", name, RUN_TIMEOUT);
            other_errs++;
            apply_reset();
        end
        else if (r_i != n_rows || rp_i != n_rows || v_i != nnz || c_i != nnz)
        begin
            $display("Error in %s: done pulsed after %0d of %0d results, %0d of %0d beats",
                     name, r_i, n_rows, v_i, nnz);
            other_errs++;
        end
    endtask

    task test_dense_small();
        clear_matrix();
        for (int r = 0; r < 4; r++)
            add_row(4, 1'b1);
        load_x();
        run_matrix("test_dense_small", 1'b0, 1'b0);
    endtask

    task test_empty_rows();
        int lens [6];
        lens = '{0, 3, 0, 0, 2, 0};
        clear_matrix();
        foreach (lens[i])
            add_row(lens[i], 1'b0);
        load_x();
        run_matrix("test_empty_rows", 1'b0, 1'b0);
    endtask

    task test_random_sparse();
        repeat (8)
        begin
            build_random(1 + $urandom % 10);
            load_x();
            run_matrix("test_random_sparse", 1'b0, 1'b0);
        end
    endtask

    task test_backpressure();
        build_random(8);
        load_x();
        repeat (2)
            run_matrix("test_backpressure", 1'b0, 1'b1);
    endtask

    task test_input_gaps();
        build_random(8);
        load_x();
        run_matrix("test_input_gaps", 1'b1, 1'b0);
    endtask

    task test_reload_vector();
        build_random(6);
        load_x();
        run_matrix("test_reload_vector", 1'b0, 1'b0);
        load_x();   // Same matrix, new x
        run_matrix("test_reload_vector", 1'b0, 1'b0);
    endtask

    task finish_run();
        $display("Errors: %0d mismatches, %0d other", mismatch_errs, other_errs);
        if (mismatch_errs + other_errs == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    endtask

    initial
    begin
        void'($urandom(32'h05e458d7));
        idle_inputs();
        rst_n = 1'b0;
        apply_reset();
        test_dense_small();
        test_empty_rows();
        test_random_sparse();
        test_backpressure();
        test_input_gaps();
        test_reload_vector();
        finish_run();
    end

endmodule

// ==== verilog.f ====
+incdir+.
spmv_pkg.sv
spmv_vector_ram.sv
spmv_mac.sv
spmv_kernel.sv
spmv_top.sv
spmv_chk.sv
spmv_tb.sv

// ==== Bender.yml ====
package:
  name: spmv

sources:
  - include_dirs:
      - .
    files:
      - spmv_pkg.sv
      - spmv_vector_ram.sv
      - spmv_mac.sv
      - spmv_kernel.sv
      - spmv_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - spmv_chk.sv
      - spmv_tb.sv
